// ==== logic/io_defs.svh ====
// bank map and timing constants; SEG_REFRESH must exceed one full shift frame plus two reads
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// bank geometry
`define IO_ADDR_W 3
`define IO_DATA_W 16
`define IO_LED_W 8
`define IO_SWT_W 8
`define KB_CODE_W 8
`define SEG_FRAME_W 32

// register addresses
`define REG_LED 3'd0
`define REG_SEG_LO 3'd1
`define REG_SEG_HI 3'd2
`define REG_KB 3'd3
`define REG_SWT 3'd4

// keyboard status flags, above the scan code byte
`define KB_VALID_BIT 8
`define KB_OVF_BIT 9
`define KB_PERR_BIT 10

// equal ps2 clock samples before a level is accepted
`define PS2_FILT 4
// clk200m cycles per half period of seg_clk
`define SEG_DIV 8
// cycles between display frame starts
`define SEG_REFRESH 2048

`endif

// ==== logic/io_pkg.sv ====
// bus types for the shared I/O bank; widths come from io_defs.svh
`include "io_defs.svh"

package io_pkg;

    typedef logic [`IO_ADDR_W-1:0] io_addr_t;
    typedef logic [`IO_DATA_W-1:0] io_word_t;
    typedef logic [`KB_CODE_W-1:0] kb_code_t;
    typedef logic [`SEG_FRAME_W-1:0] seg_frame_t;

    // kb word layout: code in [7:0], valid/ovf/perr flags at the KB_*_BIT positions
    localparam io_word_t KB_PERR_WORD = io_word_t'(1) << `KB_PERR_BIT;

    typedef enum logic [1:0] {IDLE, DATA, PARITY, STOP} ps2_state_t;
    typedef enum logic [1:0] {WAIT, READ_LO, READ_HI, SHIFT} seg_state_t;

    // bus master index
    typedef logic [1:0] master_id_t;
    localparam master_id_t M_HOST = 2'd0;
    localparam master_id_t M_PS2 = 2'd1;
    localparam master_id_t M_SEG = 2'd2;

endpackage

// ==== logic/io_regfile.sv ====
// single-port bank; reading REG_KB clears the whole kb word, REG_SWT ignores writes
`include "io_defs.svh"

module io_regfile import io_pkg::*; (
    input  logic                 clk200m,
    input  logic                 rst,
    input  logic                 bus_sel,
    input  logic                 bus_we,
    input  io_addr_t             bus_addr,
    input  io_word_t             bus_wdata,
    input  master_id_t           bus_master,
    output io_word_t             rdata,
    input  logic [`IO_SWT_W-1:0] swt,
    output logic [`IO_LED_W-1:0] leds
);

    io_word_t led_q;
    io_word_t seg_lo_q;
    io_word_t seg_hi_q;
    io_word_t kb_q;
    logic [`IO_SWT_W-1:0] swt_meta;
    logic [`IO_SWT_W-1:0] swt_sync;

    logic rd_en;
    logic wr_en;

    assign rd_en = bus_sel && !bus_we;
    assign wr_en = bus_sel && bus_we;
    assign leds = led_q[`IO_LED_W-1:0];

    // control side: led register and kb status
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            led_q <= '0;
            kb_q <= '0;
        end else if (rd_en && bus_addr == `REG_KB) begin
            // read consumes the code and all flags
            kb_q <= '0;
        end else if (wr_en) begin
            if (bus_addr == `REG_LED) begin
                led_q <= bus_wdata;
            end
            // only the ps2 receiver may post to the kb word
            if (bus_addr == `REG_KB && bus_master == M_PS2) begin
                if (bus_wdata[`KB_PERR_BIT]) begin
                    kb_q[`KB_PERR_BIT] <= 1'b1;
                end else begin
                    kb_q[`KB_CODE_W-1:0] <= bus_wdata[`KB_CODE_W-1:0];
                    kb_q[`KB_VALID_BIT] <= 1'b1;
                    // unread code overwritten
                    if (kb_q[`KB_VALID_BIT]) begin
                        kb_q[`KB_OVF_BIT] <= 1'b1;
                    end
                end
            end
        end
    end

    // display words, read data and switch sync
    always_ff @(posedge clk200m) begin
        swt_meta <= swt;
        swt_sync <= swt_meta;
        if (wr_en && bus_addr == `REG_SEG_LO) begin
            seg_lo_q <= bus_wdata;
        end
        if (wr_en && bus_addr == `REG_SEG_HI) begin
            seg_hi_q <= bus_wdata;
        end
        if (rd_en) begin
            case (bus_addr)
                `REG_LED:    rdata <= led_q;
                `REG_SEG_LO: rdata <= seg_lo_q;
                `REG_SEG_HI: rdata <= seg_hi_q;
                `REG_KB:     rdata <= kb_q;
                `REG_SWT:    rdata <= io_word_t'(swt_sync);
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

// ==== logic/io_arbiter.sv ====
// combinational round-robin grant; masters must drop req after gnt or they are granted again
`include "io_defs.svh"

module io_arbiter import io_pkg::*; (
    input  logic       clk200m,
    input  logic       rst,
    input  logic       host_req,
    input  logic       host_we,
    input  io_addr_t   host_addr,
    input  io_word_t   host_wdata,
    input  logic       ps2_req,
    input  io_word_t   ps2_wdata,
    input  logic       seg_req,
    input  io_addr_t   seg_addr,
    output logic       host_gnt,
    output logic       ps2_gnt,
    output logic       seg_gnt,
    output logic       host_rvalid,
    output logic       seg_rvalid,
    output logic       bus_sel,
    output logic       bus_we,
    output io_addr_t   bus_addr,
    output io_word_t   bus_wdata,
    output master_id_t bus_master
);

    master_id_t last_q;
    master_id_t cand;
    logic [2:0] req_vec;

    function automatic master_id_t next_id(input master_id_t m);
        return (m == M_SEG) ? M_HOST : master_id_t'(m + 2'd1);
    endfunction

    assign req_vec = {seg_req, ps2_req, host_req};

    // walk the three masters starting after the last winner
    always_comb begin
        cand = last_q;
        bus_master = last_q;
        bus_sel = 1'b0;
        for (int i = 0; i < 3; i++) begin
            cand = next_id(cand);
            if (!bus_sel && req_vec[cand]) begin
                bus_master = cand;
                bus_sel = 1'b1;
            end
        end
    end

    assign host_gnt = bus_sel && bus_master == M_HOST;
    assign ps2_gnt = bus_sel && bus_master == M_PS2;
    assign seg_gnt = bus_sel && bus_master == M_SEG;

    // ps2 always posts to REG_KB, seg only reads
    assign bus_we = host_gnt ? host_we : ps2_gnt;
    assign bus_addr = host_gnt ? host_addr : (ps2_gnt ? `REG_KB : seg_addr);
    assign bus_wdata = host_gnt ? host_wdata : (ps2_gnt ? ps2_wdata : '0);

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            last_q <= M_SEG;
            host_rvalid <= 1'b0;
            seg_rvalid <= 1'b0;
        end else begin
            if (bus_sel) begin
                last_q <= bus_master;
            end
            // rdata lands one cycle after a read grant
            host_rvalid <= host_gnt && !host_we;
            seg_rvalid <= seg_gnt;
        end
    end

endmodule

// ==== logic/ps2_rx.sv ====
// ps2 device-to-host frames only; a frame completing while req is pending is dropped
`include "io_defs.svh"

module ps2_rx import io_pkg::*; (
    input  logic     clk200m,
    input  logic     rst,
    input  logic     ps2_clk,
    input  logic     ps2_data,
    output logic     req,
    output io_word_t wdata,
    input  logic     gnt
);

    localparam int FILT = `PS2_FILT;

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic [FILT-1:0] filt_q;
    logic clk_f;
    logic fall;

    ps2_state_t state;
    logic [2:0] bit_cnt;
    kb_code_t shreg;
    logic par_ok;

    // filtered clock drops once FILT low samples are seen
    assign fall = clk_f && filt_q == '0;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync <= 2'b11;
            data_sync <= 2'b11;
            filt_q <= '1;
            clk_f <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            filt_q <= {filt_q[FILT-2:0], clk_sync[1]};
            if (fall) begin
                clk_f <= 1'b0;
            end else if (!clk_f && filt_q == '1) begin
                clk_f <= 1'b1;
            end
        end
    end

    // frame fsm, stepped on each filtered falling edge
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            bit_cnt <= '0;
            req <= 1'b0;
        end else begin
            if (gnt) begin
                req <= 1'b0;
            end
            if (fall) begin
                case (state)
                    IDLE: begin
                        // start bit is low
                        if (!data_sync[1]) begin
                            state <= DATA;
                            bit_cnt <= '0;
                        end
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: state <= STOP;
                    STOP: begin
                        state <= IDLE;
                        if (!req) begin
                            req <= 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // payload path
    always_ff @(posedge clk200m) begin
        if (fall) begin
            if (state == DATA) begin
                // lsb first
                shreg <= {data_sync[1], shreg[`KB_CODE_W-1:1]};
            end
            if (state == PARITY) begin
                // odd parity over code and parity bit
                par_ok <= ^{shreg, data_sync[1]};
            end
            if (state == STOP && !req) begin
                if (par_ok && data_sync[1]) begin
                    wdata <= io_word_t'(shreg);
                end else begin
                    wdata <= KB_PERR_WORD;
                end
            end
        end
    end

endmodule

// ==== logic/seg_refresh.sv ====
// frame = {REG_SEG_HI, REG_SEG_LO} msb first; the two reads are not atomic against host writes
`include "io_defs.svh"

module seg_refresh import io_pkg::*; (
    input  logic     clk200m,
    input  logic     rst,
    output logic     req,
    output io_addr_t addr,
    input  logic     gnt,
    input  logic     rvalid,
    input  io_word_t rdata,
    output logic     seg_clk,
    output logic     seg_clrn,
    output logic     seg_dout,
    output logic     seg_en
);

    localparam int REF_W = $clog2(`SEG_REFRESH);
    localparam int DIV_W = $clog2(`SEG_DIV);

    logic [REF_W-1:0] ref_cnt;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0] bit_cnt;
    logic granted;
    seg_state_t state;
    seg_frame_t frame;

    // request held in a read state until granted
    assign req = (state == READ_LO || state == READ_HI) && !granted;
    assign addr = (state == READ_HI) ? `REG_SEG_HI : `REG_SEG_LO;
    assign seg_dout = frame[`SEG_FRAME_W-1];

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            ref_cnt <= '0;
            div_cnt <= '0;
            bit_cnt <= '0;
            granted <= 1'b0;
            state <= WAIT;
            frame <= '0;
            seg_clk <= 1'b0;
            seg_en <= 1'b0;
            seg_clrn <= 1'b0;
        end else begin
            seg_clrn <= 1'b1;
            // free-running frame timer
            ref_cnt <= ref_cnt + 1'b1;
            if (gnt) begin
                granted <= 1'b1;
            end
            case (state)
                WAIT: begin
                    if (ref_cnt == REF_W'(`SEG_REFRESH - 1)) begin
                        state <= READ_LO;
                    end
                end
                READ_LO: begin
                    if (rvalid) begin
                        frame[`IO_DATA_W-1:0] <= rdata;
                        granted <= 1'b0;
                        state <= READ_HI;
                    end
                end
                READ_HI: begin
                    if (rvalid) begin
                        frame[`SEG_FRAME_W-1:`IO_DATA_W] <= rdata;
                        granted <= 1'b0;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        seg_clk <= 1'b0;
                        seg_en <= 1'b1;
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (div_cnt == DIV_W'(`SEG_DIV - 1)) begin
                        div_cnt <= '0;
                        seg_clk <= !seg_clk;
                        // next bit goes out on the falling edge
                        if (seg_clk) begin
                            if (bit_cnt == 5'd31) begin
                                seg_en <= 1'b0;
                                state <= WAIT;
                            end else begin
                                bit_cnt <= bit_cnt + 5'd1;
                                frame <= {frame[`SEG_FRAME_W-2:0], 1'b0};
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= WAIT;
            endcase
        end
    end

endmodule

// ==== logic/io_top.sv ====
// host port follows the bank timing: req held until gnt, rdata valid with host_rvalid
`include "io_defs.svh"

module io_top import io_pkg::*; (
    input  logic                 clk200m,
    input  logic                 rst,
    input  logic                 host_req,
    input  logic                 host_we,
    input  io_addr_t             host_addr,
    input  io_word_t             host_wdata,
    output logic                 host_gnt,
    output logic                 host_rvalid,
    output io_word_t             host_rdata,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic [`IO_SWT_W-1:0] swt,
    output logic [`IO_LED_W-1:0] leds,
    output logic                 seg_clk,
    output logic                 seg_clrn,
    output logic                 seg_dout,
    output logic                 seg_en
);

    // bank side
    logic bus_sel;
    logic bus_we;
    io_addr_t bus_addr;
    io_word_t bus_wdata;
    master_id_t bus_master;

    // peripheral masters
    logic ps2_req;
    logic ps2_gnt;
    io_word_t ps2_wdata;
    logic seg_req;
    logic seg_gnt;
    logic seg_rvalid;
    io_addr_t seg_addr;

    io_arbiter i_io_arbiter (
        .clk200m     (clk200m),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .ps2_req     (ps2_req),
        .ps2_wdata   (ps2_wdata),
        .seg_req     (seg_req),
        .seg_addr    (seg_addr),
        .host_gnt    (host_gnt),
        .ps2_gnt     (ps2_gnt),
        .seg_gnt     (seg_gnt),
        .host_rvalid (host_rvalid),
        .seg_rvalid  (seg_rvalid),
        .bus_sel     (bus_sel),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_master  (bus_master)
    );

    // shared read bus goes to the host and the refresher
    io_regfile i_io_regfile (
        .clk200m    (clk200m),
        .rst        (rst),
        .bus_sel    (bus_sel),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_master (bus_master),
        .rdata      (host_rdata),
        .swt        (swt),
        .leds       (leds)
    );

    ps2_rx i_ps2_rx (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .req      (ps2_req),
        .wdata    (ps2_wdata),
        .gnt      (ps2_gnt)
    );

    seg_refresh i_seg_refresh (
        .clk200m  (clk200m),
        .rst      (rst),
        .req      (seg_req),
        .addr     (seg_addr),
        .gnt      (seg_gnt),
        .rvalid   (seg_rvalid),
        .rdata    (host_rdata),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dout (seg_dout),
        .seg_en   (seg_en)
    );

endmodule

// ==== sim/io_props.sv ====
// bound into io_arbiter; assumes each master lowers req the cycle after its grant
module io_props (
    input logic clk200m,
    input logic rst,
    input logic host_req,
    input logic host_we,
    input logic ps2_req,
    input logic seg_req,
    input logic host_gnt,
    input logic ps2_gnt,
    input logic seg_gnt,
    input logic host_rvalid,
    input logic seg_rvalid
);

    // ungranted cycles per pending request
    logic [2:0] host_wait;
    logic [2:0] ps2_wait;
    logic [2:0] seg_wait;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            host_wait <= '0;
            ps2_wait <= '0;
            seg_wait <= '0;
        end else begin
            host_wait <= (host_req && !host_gnt) ? host_wait + 3'd1 : 3'd0;
            ps2_wait <= (ps2_req && !ps2_gnt) ? ps2_wait + 3'd1 : 3'd0;
            seg_wait <= (seg_req && !seg_gnt) ? seg_wait + 3'd1 : 3'd0;
        end
    end

    // at most one grant and only to a requesting master
    a_one_grant: assert property (@(posedge clk200m) disable iff (rst)
        $onehot0({host_gnt, ps2_gnt, seg_gnt})
        && (!host_gnt || host_req) && (!ps2_gnt || ps2_req) && (!seg_gnt || seg_req))
        else $error("more than one grant in one cycle or a grant without a request");

    // read data valid exactly one cycle after a read grant
    a_host_rvalid: assert property (@(posedge clk200m) disable iff (rst)
        (host_gnt && !host_we) |=> host_rvalid)
        else $error("host_rvalid missing after host read grant");
    a_host_rvalid_src: assert property (@(posedge clk200m) disable iff (rst)
        host_rvalid |-> $past(host_gnt && !host_we))
        else $error("host_rvalid without a host read grant");
    a_seg_rvalid: assert property (@(posedge clk200m) disable iff (rst)
        seg_gnt |=> seg_rvalid)
        else $error("seg_rvalid missing after seg grant");
    a_seg_rvalid_src: assert property (@(posedge clk200m) disable iff (rst)
        seg_rvalid |-> $past(seg_gnt))
        else $error("seg_rvalid without a seg grant");

    // at most two other grants before a held request wins
    a_host_wait: assert property (@(posedge clk200m) disable iff (rst)
        host_req |-> host_wait < 3'd3)
        else $error("host request waited more than 2 cycles");
    a_ps2_wait: assert property (@(posedge clk200m) disable iff (rst)
        ps2_req |-> ps2_wait < 3'd3)
        else $error("ps2 request waited more than 2 cycles");
    a_seg_wait: assert property (@(posedge clk200m) disable iff (rst)
        seg_req |-> seg_wait < 3'd3)
        else $error("seg request waited more than 2 cycles");

endmodule

bind io_arbiter io_props i_io_props (
    .clk200m     (clk200m),
    .rst         (rst),
    .host_req    (host_req),
    .host_we     (host_we),
    .ps2_req     (ps2_req),
    .seg_req     (seg_req),
    .host_gnt    (host_gnt),
    .ps2_gnt     (ps2_gnt),
    .seg_gnt     (seg_gnt),
    .host_rvalid (host_rvalid),
    .seg_rvalid  (seg_rvalid)
);

// ==== sim/io_tb.sv ====
// drives io_top from clk200m only; a segment capture skips one frame, so it takes up to two refreshes
`include "io_defs.svh"

module io_tb import io_pkg::*; ();

    localparam int HALF = 20;
    localparam int PS2_HALF = 20;
    localparam int PS2_GAP = 60;
    localparam int GNT_TIMEOUT = 16;
    localparam int RVALID_TIMEOUT = 4;
    localparam int SEG_TIMEOUT = 3 * `SEG_REFRESH;
    localparam int N_ROWS = 20;

    // kb status word flags, from the bit positions
    localparam logic [15:0] KB_VALID = 16'd1 << `KB_VALID_BIT;
    localparam logic [15:0] KB_OVF = 16'd1 << `KB_OVF_BIT;
    localparam logic [15:0] KB_PERR = 16'd1 << `KB_PERR_BIT;

    typedef enum logic [2:0] {
        OP_WR, OP_RD, OP_SWT, OP_PS2, OP_PS2_BADPAR, OP_PS2_BADSTOP, OP_SEG
    } op_t;

    logic clk200m;
    logic rst;
    logic host_req;
    logic host_we;
    io_addr_t host_addr;
    io_word_t host_wdata;
    logic host_gnt;
    logic host_rvalid;
    io_word_t host_rdata;
    logic ps2_clk;
    logic ps2_data;
    logic [7:0] swt;
    logic [7:0] leds;
    logic seg_clk;
    logic seg_clrn;
    logic seg_dout;
    logic seg_en;

    // stimulus table
    op_t tbl_op[N_ROWS];
    io_addr_t tbl_addr[N_ROWS];
    logic [31:0] tbl_data[N_ROWS];
    logic [31:0] tbl_exp[N_ROWS];
    string tbl_name[N_ROWS];
    int n_rows = 0;

    logic [31:0] lfsr_q = 32'ha204;
    int row_errs = 0;
    int err_cnt = 0;
    int tests_run = 0;
    int tests_failed = 0;

    io_top i_io_top (
        .clk200m     (clk200m),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .swt         (swt),
        .leds        (leds),
        .seg_clk     (seg_clk),
        .seg_clrn    (seg_clrn),
        .seg_dout    (seg_dout),
        .seg_en      (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever begin
            #(HALF) clk200m = ~clk200m;
        end
    end

    // galois form, shift right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic add_row(input op_t op, input io_addr_t a, input logic [31:0] d,
                           input logic [31:0] e, input string name);
        tbl_op[n_rows] = op;
        tbl_addr[n_rows] = a;
        tbl_data[n_rows] = d;
        tbl_exp[n_rows] = e;
        tbl_name[n_rows] = name;
        n_rows++;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
        row_errs++;
        err_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        row_errs++;
        err_cnt++;
    endtask

    // one bus access through the host port, ends on the falling edge after grant or rvalid
    task automatic host_access(input logic we, input io_addr_t a, input io_word_t d,
                               output io_word_t rd);
        int n;
        logic got;
        rd = '0;
        @(negedge clk200m);
        host_req = 1'b1;
        host_we = we;
        host_addr = a;
        host_wdata = d;
        got = 1'b0;
        n = 0;
        while (!got && n < GNT_TIMEOUT) begin
            // grant is combinational, look mid low phase
            #(HALF / 2);
            got = host_gnt;
            @(negedge clk200m);
            n++;
        end
        host_req = 1'b0;
        host_we = 1'b0;
        if (!got) begin
            report_failure("host_gnt never came for the host access");
        end else if (!we) begin
            n = 0;
            while (!host_rvalid && n < RVALID_TIMEOUT) begin
                @(negedge clk200m);
                n++;
            end
            if (host_rvalid) begin
                rd = host_rdata;
            end else begin
                report_failure("host_rvalid never came after a read grant");
            end
        end
    endtask

    // start, 8 data lsb first, odd parity, stop; data moves while ps2_clk is high
    task automatic send_ps2(input logic [7:0] code, input logic bad_par,
                            input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};
        @(negedge clk200m);
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (PS2_HALF) @(negedge clk200m);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk200m);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        // room for the receiver to post its word
        repeat (PS2_GAP) @(negedge clk200m);
    endtask

    task automatic wait_seg_en(input logic level, output logic ok);
        int n;
        n = 0;
        while (seg_en !== level && n < SEG_TIMEOUT) begin
            @(negedge clk200m);
            n++;
        end
        ok = (seg_en === level);
    endtask

    // skip the frame in flight, it may carry stale words
    task automatic capture_seg(output logic [31:0] frame, output int rises);
        int n;
        logic prev_clk;
        logic ok;
        frame = '0;
        rises = 0;
        wait_seg_en(1'b1, ok);
        if (ok) begin
            wait_seg_en(1'b0, ok);
        end
        if (ok) begin
            wait_seg_en(1'b1, ok);
        end
        if (!ok) begin
            report_failure("seg_en did not toggle within the refresh timeout");
        end else begin
            prev_clk = seg_clk;
            n = 0;
            while (seg_en && n < SEG_TIMEOUT) begin
                @(negedge clk200m);
                // rising seg_clk seen while the frame is still enabled
                if (seg_en && seg_clk && !prev_clk) begin
                    frame = {frame[30:0], seg_dout};
                    rises++;
                end
                prev_clk = seg_clk;
                n++;
            end
            if (seg_en) begin
                report_failure("seg_en stayed high past the timeout");
            end
        end
    endtask

    initial begin
        logic [31:0] led_d;
        logic [31:0] sw;
        logic [31:0] junk;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] c3;
        logic [31:0] c4;
        logic [31:0] c5;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] frame;
        int rises;
        io_word_t rd;

        rst = 1'b1;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        swt = '0;

        take_bits(16, led_d);
        take_bits(8, sw);
        take_bits(16, junk);
        take_bits(8, c1);
        take_bits(8, c2);
        take_bits(8, c3);
        take_bits(8, c4);
        take_bits(8, c5);
        take_bits(16, hi);
        take_bits(16, lo);

        add_row(OP_WR, `REG_LED, led_d, led_d, "led write");
        add_row(OP_RD, `REG_LED, 0, led_d, "led read back");
        add_row(OP_SWT, `REG_SWT, sw, sw, "switch set");
        add_row(OP_RD, `REG_SWT, 0, sw, "switch read");
        add_row(OP_WR, `REG_SWT, junk, 0, "switch write ignored");
        add_row(OP_RD, `REG_SWT, 0, sw, "switch read after write");
        add_row(OP_PS2, `REG_KB, c1, 0, "ps2 good frame");
        add_row(OP_RD, `REG_KB, 0, KB_VALID | c1[15:0], "kb code with valid");
        add_row(OP_RD, `REG_KB, 0, 0, "kb cleared by read");
        add_row(OP_PS2_BADPAR, `REG_KB, c2, 0, "ps2 bad parity frame");
        add_row(OP_RD, `REG_KB, 0, KB_PERR, "kb parity error only");
        add_row(OP_PS2_BADSTOP, `REG_KB, c3, 0, "ps2 bad stop frame");
        add_row(OP_RD, `REG_KB, 0, KB_PERR, "kb error on bad stop");
        add_row(OP_PS2, `REG_KB, c4, 0, "ps2 first of two");
        add_row(OP_PS2, `REG_KB, c5, 0, "ps2 second of two");
        add_row(OP_RD, `REG_KB, 0, KB_VALID | KB_OVF | c5[15:0], "kb overflow");
        add_row(OP_RD, `REG_KB, 0, 0, "kb cleared after overflow");
        add_row(OP_WR, `REG_SEG_HI, hi, hi, "seg high word write");
        add_row(OP_WR, `REG_SEG_LO, lo, lo, "seg low word write");
        add_row(OP_SEG, `REG_SEG_LO, 0, {hi[15:0], lo[15:0]}, "seg frame capture");

        repeat (2) @(negedge clk200m);
        rst = 1'b0;
        @(negedge clk200m);

        // outputs right after reset
        row_errs = 0;
        if (host_gnt !== 1'b0 || host_rvalid !== 1'b0) begin
            report_mismatch("host gnt/rvalid after reset", {host_gnt, host_rvalid}, 0);
        end
        if (seg_en !== 1'b0 || seg_clk !== 1'b0) begin
            report_mismatch("seg_en/seg_clk after reset", {seg_en, seg_clk}, 0);
        end
        if (leds !== 8'h00) begin
            report_mismatch("leds after reset", leds, 0);
        end
        if (seg_clrn !== 1'b1) begin
            report_mismatch("seg_clrn after reset", seg_clrn, 1);
        end
        tests_run++;
        if (row_errs != 0) begin
            tests_failed++;
        end
        $display("test 0 reset state: %s", row_errs == 0 ? "ok" : "failed");

        for (int r = 0; r < n_rows; r++) begin
            row_errs = 0;
            case (tbl_op[r])
                OP_WR: begin
                    host_access(1'b1, tbl_addr[r], tbl_data[r][15:0], rd);
                    // leds follow the led register one edge after the grant
                    if (tbl_addr[r] == `REG_LED && leds !== tbl_exp[r][7:0]) begin
                        report_mismatch("leds", leds, tbl_exp[r][7:0]);
                    end
                end
                OP_RD: begin
                    host_access(1'b0, tbl_addr[r], '0, rd);
                    if (rd !== tbl_exp[r][15:0]) begin
                        report_mismatch(tbl_name[r], rd, tbl_exp[r][15:0]);
                    end
                end
                OP_SWT: begin
                    @(negedge clk200m);
                    swt = tbl_data[r][7:0];
                    // two sync flops before readable
                    repeat (2) @(negedge clk200m);
                end
                OP_PS2: send_ps2(tbl_data[r][7:0], 1'b0, 1'b0);
                OP_PS2_BADPAR: send_ps2(tbl_data[r][7:0], 1'b1, 1'b0);
                OP_PS2_BADSTOP: send_ps2(tbl_data[r][7:0], 1'b0, 1'b1);
                OP_SEG: begin
                    capture_seg(frame, rises);
                    if (frame !== tbl_exp[r]) begin
                        report_mismatch("segment frame", frame, tbl_exp[r]);
                    end
                    if (rises != 32) begin
                        report_mismatch("seg_clk rises while seg_en", rises, 32);
                    end
                end
                default: report_failure("unknown table operation");
            endcase
            tests_run++;
            if (row_errs != 0) begin
                tests_failed++;
            end
            $display("test %0d %s: %s", r + 1, tbl_name[r], row_errs == 0 ? "ok" : "failed");
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/io_pkg.sv
logic/io_regfile.sv
logic/io_arbiter.sv
logic/ps2_rx.sv
logic/seg_refresh.sv
logic/io_top.sv
sim/io_props.sv
sim/io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module io_tb -o io_tb_sim &&
./obj_dir/io_tb_sim | tee /dev/stderr | grep -q "^Finished with no errors$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
